// File: hw/afe_pkg.sv
// Analog front-end shared definitions
// Sample, gain and offset types, APB geometry, region map and reset values

package afe_pkg;

  // Sample path
  localparam int SMP_W = 14;
  typedef logic signed [SMP_W-1:0] sample_t;
  typedef logic signed [SMP_W-1:0] offset_t;
  localparam sample_t SMP_MAX = sample_t'(14'h1fff);
  localparam sample_t SMP_MIN = sample_t'(14'h2000);

  // Gain in fixed point, 2 integer and 14 fractional bits
  localparam int GAIN_W    = 16;
  localparam int GAIN_FRAC = 14;
  typedef logic signed [GAIN_W-1:0] gain_t;
  localparam gain_t GAIN_UNITY = gain_t'(16384);

  // APB geometry, region select in the top address bits
  localparam int APB_AW      = 16;
  localparam int APB_DW      = 32;
  localparam int REG_SEL_LSB = 12;
  localparam int REG_W       = APB_AW - REG_SEL_LSB;
  typedef logic [REG_W-1:0] region_t;
  localparam region_t REG_HK  = region_t'(0);
  localparam region_t REG_CAL = region_t'(1);

  // Housekeeping constants
  localparam logic [APB_DW-1:0] AFE_ID = 32'h4146_4501;
  localparam logic [7:0] LED_RST  = 8'h00;
  localparam offset_t    OFFS_RST = offset_t'(0);

endpackage

// File: hw/apb_if.sv
// APB bus bundle between the address decoder and the register blocks
// Requester side drives the request, completer side answers

`timescale 1ns/1ps

interface apb_if;
  import afe_pkg::*;

  // Request
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;

  // Response
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Decoder side
  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Register block side
  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// File: hw/apb_decoder.sv
// APB address decoder
// Splits the top APB bus into regions by address bits 15:12,
// forwards the request to one completer and returns its response.
// Regions without a completer get an immediate error

`timescale 1ns/1ps

module apb_decoder (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [afe_pkg::APB_AW-1:0]  paddr_i,
  input  logic [afe_pkg::APB_DW-1:0]  pwdata_i,
  output logic [afe_pkg::APB_DW-1:0]  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  apb_if.requester                    hk_bus,
  apb_if.requester                    cal_bus
);
  import afe_pkg::*;

  region_t region;
  logic    hk_hit;
  logic    cal_hit;

  // Region number from the top address nibble
  assign region  = paddr_i[APB_AW-1:REG_SEL_LSB];
  assign hk_hit  = (region == REG_HK);
  assign cal_hit = (region == REG_CAL);

  //////////////////////////////////////////////////////////////////////
  // Request fan-out
  //////////////////////////////////////////////////////////////////////

  // Select and enable only reach the hit completer
  assign hk_bus.psel    = psel_i & hk_hit;
  assign hk_bus.penable = penable_i & hk_hit;
  assign hk_bus.pwrite  = pwrite_i;
  assign hk_bus.paddr   = paddr_i;
  assign hk_bus.pwdata  = pwdata_i;

  assign cal_bus.psel    = psel_i & cal_hit;
  assign cal_bus.penable = penable_i & cal_hit;
  assign cal_bus.pwrite  = pwrite_i;
  assign cal_bus.paddr   = paddr_i;
  assign cal_bus.pwdata  = pwdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (hk_hit) begin
      prdata_o  = hk_bus.prdata;
      pready_o  = hk_bus.pready;
      pslverr_o = hk_bus.pslverr;
    end else if (cal_hit) begin
      prdata_o  = cal_bus.prdata;
      pready_o  = cal_bus.pready;
      pslverr_o = cal_bus.pslverr;
    end else begin
      // Unmapped region, finish in the access phase with an error
      prdata_o  = '0;
      pready_o  = psel_i & penable_i;
      pslverr_o = psel_i & penable_i;
    end
  end

  // Never two completers selected at once
  a_one_sel: assert property (@(posedge adc_clk) disable iff (top_rst)
    $onehot0({hk_bus.psel, cal_bus.psel}));

endmodule

// File: hw/hk_regs.sv
// Housekeeping registers
// ID word, loopback control and LED register on an APB completer port.
// Zero wait states, error on unknown offsets and on ID writes

`timescale 1ns/1ps

module hk_regs (
  input  logic       adc_clk,
  input  logic       top_rst,
  apb_if.completer   bus,
  output logic       loop_en_o,
  output logic [7:0] led_o
);
  import afe_pkg::*;

  // Register offsets inside the region
  localparam logic [REG_SEL_LSB-1:0] OFS_ID   = 12'h000;
  localparam logic [REG_SEL_LSB-1:0] OFS_CTRL = 12'h004;
  localparam logic [REG_SEL_LSB-1:0] OFS_LED  = 12'h008;

  logic [REG_SEL_LSB-1:0] ofs;
  logic [APB_DW-1:0]      rd_data;
  logic                   access;
  logic                   unmapped;
  logic                   err;
  logic                   wr_en;

  assign ofs    = bus.paddr[REG_SEL_LSB-1:0];
  assign access = bus.psel & bus.penable;

  // Read mux, also flags offsets outside the map
  always_comb begin
    rd_data  = '0;
    unmapped = 1'b0;
    case (ofs)
      OFS_ID:   rd_data = AFE_ID;
      OFS_CTRL: rd_data[0] = loop_en_o;
      OFS_LED:  rd_data[7:0] = led_o;
      default:  unmapped = 1'b1;
    endcase
  end

  // ID is read only
  assign err   = unmapped | (bus.pwrite & (ofs == OFS_ID));
  assign wr_en = access & bus.pwrite & ~err;

  assign bus.prdata  = rd_data;
  assign bus.pready  = access;
  assign bus.pslverr = access & err;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_en_o <= 1'b0;
      led_o     <= LED_RST;
    end else if (wr_en) begin
      if (ofs == OFS_CTRL) loop_en_o <= bus.pwdata[0];
      if (ofs == OFS_LED)  led_o     <= bus.pwdata[7:0];
    end
  end

  // Decoder gating keeps enable inside a selected transfer
  a_en_sel: assert property (@(posedge adc_clk) disable iff (top_rst)
    bus.penable |-> bus.psel);

endmodule

// File: hw/calib_regs.sv
// Calibration register file
// Per channel ADC gain, ADC offset, DAC gain and DAC offset.
// Channel c sits at c*0x10, words at +0x0, +0x4, +0x8, +0xC.
// Read data is sign extended, writes keep the low bits

`timescale 1ns/1ps

module calib_regs #(
  parameter int unsigned NUM_CH = 2
) (
  input  logic             adc_clk,
  input  logic             top_rst,
  apb_if.completer         bus,
  output afe_pkg::gain_t   adc_gain_o [NUM_CH],
  output afe_pkg::offset_t adc_offs_o [NUM_CH],
  output afe_pkg::gain_t   dac_gain_o [NUM_CH],
  output afe_pkg::offset_t dac_offs_o [NUM_CH]
);
  import afe_pkg::*;

  // Channel index starts above the 16 byte channel window
  localparam int CH_LSB = 4;

  logic [REG_SEL_LSB-1:CH_LSB] chan;
  logic [1:0]                  word;
  logic                        access;
  logic                        err;
  logic                        wr_en;
  logic [APB_DW-1:0]           rd_data;

  assign chan   = bus.paddr[REG_SEL_LSB-1:CH_LSB];
  assign word   = bus.paddr[CH_LSB-1:2];
  assign access = bus.psel & bus.penable;

  // Channel out of range or a misaligned byte address
  assign err   = (chan >= NUM_CH) | (bus.paddr[1:0] != 2'b00);
  assign wr_en = access & bus.pwrite & ~err;

  //////////////////////////////////////////////////////////////////////
  // Read back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (chan == c) begin
        case (word)
          2'd0:    rd_data = APB_DW'(adc_gain_o[c]);
          2'd1:    rd_data = APB_DW'(adc_offs_o[c]);
          2'd2:    rd_data = APB_DW'(dac_gain_o[c]);
          default: rd_data = APB_DW'(dac_offs_o[c]);
        endcase
      end
    end
    if (err) rd_data = '0;
  end

  assign bus.prdata  = rd_data;
  assign bus.pready  = access;
  assign bus.pslverr = access & err;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      // Unity gain, no offset
      for (int c = 0; c < NUM_CH; c++) begin
        adc_gain_o[c] <= GAIN_UNITY;
        adc_offs_o[c] <= OFFS_RST;
        dac_gain_o[c] <= GAIN_UNITY;
        dac_offs_o[c] <= OFFS_RST;
      end
    end else if (wr_en) begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (chan == c) begin
          case (word)
            2'd0:    adc_gain_o[c] <= gain_t'(bus.pwdata[GAIN_W-1:0]);
            2'd1:    adc_offs_o[c] <= offset_t'(bus.pwdata[SMP_W-1:0]);
            2'd2:    dac_gain_o[c] <= gain_t'(bus.pwdata[GAIN_W-1:0]);
            default: dac_offs_o[c] <= offset_t'(bus.pwdata[SMP_W-1:0]);
          endcase
        end
      end
    end
  end

endmodule

// File: hw/linear_cal.sv
// Linear calibration stage computing sat(floor(x * gain / 2^14) + offset)
// Two register stages taking a new sample every cycle

`timescale 1ns/1ps

module linear_cal (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  afe_pkg::sample_t smp_i,
  input  afe_pkg::gain_t   gain_i,
  input  afe_pkg::offset_t offs_i,
  output afe_pkg::sample_t smp_o
);
  import afe_pkg::*;

  localparam int PROD_W = SMP_W + GAIN_W;
  // Scaled product plus offset with one guard bit
  localparam int SUM_W  = PROD_W - GAIN_FRAC + 1;

  logic signed [PROD_W-1:0] prod_q;
  logic signed [PROD_W-1:0] prod_shr;
  logic signed [SUM_W-1:0]  sum;
  offset_t                  offs_q;
  sample_t                  sat;

  // Stage 1 registers the full width product
  // Offset travels along so gain and offset change together
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      offs_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
      offs_q <= offs_i;
    end
  end

  // Floor division by 2^GAIN_FRAC
  assign prod_shr = prod_q >>> GAIN_FRAC;
  assign sum      = SUM_W'(prod_shr) + SUM_W'(offs_q);

  // Clamp to the 14 bit range
  always_comb begin
    if (sum > SUM_W'(SMP_MAX)) begin
      sat = SMP_MAX;
    end else if (sum < SUM_W'(SMP_MIN)) begin
      sat = SMP_MIN;
    end else begin
      sat = sample_t'(sum);
    end
  end

  // Stage 2
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) smp_o <= '0;
    else         smp_o <= sat;
  end

  // Terms of one sign keep that sign through the clamp
  a_no_wrap_pos: assert property (@(posedge adc_clk) disable iff (top_rst)
    !prod_shr[PROD_W-1] && !offs_q[SMP_W-1] |=> !smp_o[SMP_W-1]);

  a_no_wrap_neg: assert property (@(posedge adc_clk) disable iff (top_rst)
    prod_shr[PROD_W-1] && offs_q[SMP_W-1] |=> smp_o[SMP_W-1]);

endmodule

// File: hw/afe_channel.sv
// One analog front-end channel
// ADC code conversion, loopback select and calibration on the way in,
// calibration and DAC code conversion on the way out

`timescale 1ns/1ps

module afe_channel (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  logic [afe_pkg::SMP_W-1:0] adc_raw_i,
  input  afe_pkg::sample_t          dac_src_i,
  input  logic                      loop_en_i,
  input  afe_pkg::gain_t            adc_gain_i,
  input  afe_pkg::offset_t          adc_offs_i,
  input  afe_pkg::gain_t            dac_gain_i,
  input  afe_pkg::offset_t          dac_offs_i,
  output afe_pkg::sample_t          adc_smp_o,
  output logic [afe_pkg::SMP_W-1:0] dac_code_o
);
  import afe_pkg::*;

  sample_t adc_raw_q;
  sample_t adc_mux;
  sample_t dac_cal;

  //////////////////////////////////////////////////////////////////////
  // ADC side
  //////////////////////////////////////////////////////////////////////

  // Unsigned negative slope code to two's complement
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) adc_raw_q <= '0;
    else         adc_raw_q <= {adc_raw_i[SMP_W-1], ~adc_raw_i[SMP_W-2:0]};
  end

  // Loopback takes the calibrated DAC stream instead
  assign adc_mux = loop_en_i ? dac_cal : adc_raw_q;

  linear_cal u_adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (adc_mux),
    .gain_i  (adc_gain_i),
    .offs_i  (adc_offs_i),
    .smp_o   (adc_smp_o)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC side
  //////////////////////////////////////////////////////////////////////

  linear_cal u_dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (dac_src_i),
    .gain_i  (dac_gain_i),
    .offs_i  (dac_offs_i),
    .smp_o   (dac_cal)
  );

  // Back to unsigned negative slope code
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) dac_code_o <= '0;
    else         dac_code_o <= {dac_cal[SMP_W-1], ~dac_cal[SMP_W-2:0]};
  end

endmodule

// File: hw/afe_top.sv
// Two channel analog front-end datapath top level
// APB decoder, housekeeping and calibration registers, channel array

`timescale 1ns/1ps

module afe_top #(
  parameter int unsigned NUM_CH = 2
) (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // APB
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  logic [afe_pkg::APB_AW-1:0]              paddr_i,
  input  logic [afe_pkg::APB_DW-1:0]              pwdata_i,
  output logic [afe_pkg::APB_DW-1:0]              prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  // Sample streams
  input  logic [NUM_CH-1:0][afe_pkg::SMP_W-1:0]   adc_dat_i,
  input  afe_pkg::sample_t                        dac_src_i [NUM_CH],
  output afe_pkg::sample_t                        adc_dat_o [NUM_CH],
  output logic [NUM_CH-1:0][afe_pkg::SMP_W-1:0]   dac_dat_o,
  // Board LEDs
  output logic [7:0]                              led_o
);
  import afe_pkg::*;

  apb_if hk_bus ();
  apb_if cal_bus ();

  logic    loop_en;
  gain_t   adc_gain [NUM_CH];
  offset_t adc_offs [NUM_CH];
  gain_t   dac_gain [NUM_CH];
  offset_t dac_offs [NUM_CH];

  //////////////////////////////////////////////////////////////////////
  // Register bus
  //////////////////////////////////////////////////////////////////////

  apb_decoder u_dec (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .hk_bus    (hk_bus),
    .cal_bus   (cal_bus)
  );

  hk_regs u_hk (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus       (hk_bus),
    .loop_en_o (loop_en),
    .led_o     (led_o)
  );

  calib_regs #(
    .NUM_CH (NUM_CH)
  ) u_cal (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .bus        (cal_bus),
    .adc_gain_o (adc_gain),
    .adc_offs_o (adc_offs),
    .dac_gain_o (dac_gain),
    .dac_offs_o (dac_offs)
  );

  //////////////////////////////////////////////////////////////////////
  // Channels
  //////////////////////////////////////////////////////////////////////

  // Loopback enable is shared by all channels
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    afe_channel u_ch (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .adc_raw_i  (adc_dat_i[c]),
      .dac_src_i  (dac_src_i[c]),
      .loop_en_i  (loop_en),
      .adc_gain_i (adc_gain[c]),
      .adc_offs_i (adc_offs[c]),
      .dac_gain_i (dac_gain[c]),
      .dac_offs_i (dac_offs[c]),
      .adc_smp_o  (adc_dat_o[c]),
      .dac_code_o (dac_dat_o[c])
    );
  end

endmodule

// File: tests/afe_tb.sv
// Testbench for the two channel analog front-end
// APB register checks, error responses, ADC, DAC and loopback streams
// compared against a behavioral model of the calibration rule

`timescale 1ns/1ps

module afe_tb;
  import afe_pkg::*;

  localparam int NUM_CH    = 2;
  localparam int N_SMP     = 800;
  localparam int N_STREAMS = 12;
  // Roughly twice the streams plus their register traffic
  localparam int MAX_CYC   = 2 * (N_STREAMS * (N_SMP + 40) + 400);

  logic                         adc_clk;
  logic                         top_rst;
  logic                         psel_i;
  logic                         penable_i;
  logic                         pwrite_i;
  logic [APB_AW-1:0]            paddr_i;
  logic [APB_DW-1:0]            pwdata_i;
  logic [APB_DW-1:0]            prdata_o;
  logic                         pready_o;
  logic                         pslverr_o;
  logic [NUM_CH-1:0][SMP_W-1:0] adc_dat_i;
  sample_t                      dac_src_i [NUM_CH];
  sample_t                      adc_dat_o [NUM_CH];
  logic [NUM_CH-1:0][SMP_W-1:0] dac_dat_o;
  logic [7:0]                   led_o;

  // Model state
  logic [31:0] lfsr;
  logic        m_loop;
  logic [7:0]  m_led;
  gain_t       m_adc_gain [NUM_CH];
  offset_t     m_adc_offs [NUM_CH];
  gain_t       m_dac_gain [NUM_CH];
  offset_t     m_dac_offs [NUM_CH];
  // Delay lines with the newest sample at index 0
  int          dl_adc [NUM_CH][4];
  int          dl_dac [NUM_CH][4];
  int          sat_hi;
  int          sat_lo;
  int          cycles;

  afe_top #(.NUM_CH(NUM_CH)) u_dut (
    .adc_clk(adc_clk), .top_rst(top_rst),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o),
    .adc_dat_i(adc_dat_i), .dac_src_i(dac_src_i),
    .adc_dat_o(adc_dat_o), .dac_dat_o(dac_dat_o), .led_o(led_o)
  );

  always #50 adc_clk = ~adc_clk;

  // Run limit
  always @(posedge adc_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYC);
      $display("Test failed");
      $fatal(1, "run limit reached");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Negative slope code where 0 is full scale positive
  function automatic int raw_to_smp(input logic [SMP_W-1:0] raw);
    return 8191 - int'(raw);
  endfunction

  function automatic logic [SMP_W-1:0] smp_to_code(input int v);
    return SMP_W'(8191 - v);
  endfunction

  // sat(floor(x * g / 2^14) + o)
  function automatic int cal_model(input int x, input int g, input int o);
    int p;
    int q;
    int s;
    p = x * g;
    q = p / 16384;
    if ((p < 0) && (q * 16384 != p)) q = q - 1;
    s = q + o;
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return s;
  endfunction

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (expected !== actual) begin
      $display("Error at %0t: %s, expected %h, got %h", $time, what, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB access
  //////////////////////////////////////////////////////////////////////

  // Setup then access phase with the response sampled mid cycle
  task automatic bus_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge adc_clk);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    // No response before the access phase
    @(negedge adc_clk);
    check(32'd0, {30'b0, pready_o, pslverr_o}, "pready_o and pslverr_o in setup phase");
    @(posedge adc_clk);
    #1;
    penable_i = 1'b1;
    @(negedge adc_clk);
    while (!pready_o) @(negedge adc_clk);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge adc_clk);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [15:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b1, addr, wdata, rd, err);
    check({31'b0, exp_err}, {31'b0, err}, $sformatf("pslverr on write to %h", addr));
  endtask

  task automatic reg_read(input logic [15:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b0, addr, '0, rd, err);
    check({31'b0, exp_err}, {31'b0, err}, $sformatf("pslverr on read of %h", addr));
    check(exp_data, rd, $sformatf("read data at %h", addr));
  endtask

  function automatic logic [15:0] cal_addr(input int c, input int w);
    return 16'h1000 + 16'(c * 16 + w * 4);
  endfunction

  // Gains keep the low 16 bits and offsets the low 14
  task automatic write_cal(input int c, input int w, input logic [31:0] d);
    reg_write(cal_addr(c, w), d, 1'b0);
    case (w)
      0:       m_adc_gain[c] = gain_t'(d[15:0]);
      1:       m_adc_offs[c] = offset_t'(d[13:0]);
      2:       m_dac_gain[c] = gain_t'(d[15:0]);
      default: m_dac_offs[c] = offset_t'(d[13:0]);
    endcase
  endtask

  task automatic randomize_cal();
    for (int c = 0; c < NUM_CH; c++) begin
      for (int w = 0; w < 4; w++) write_cal(c, w, rand_bits(32));
    end
  endtask

  task automatic set_loop(input logic en);
    reg_write(16'h0004, {31'b0, en}, 1'b0);
    m_loop = en;
  endtask

  // Full register readback with sign extended values
  task automatic check_regs();
    reg_read(16'h0000, AFE_ID, 1'b0);
    reg_read(16'h0004, {31'b0, m_loop}, 1'b0);
    reg_read(16'h0008, {24'b0, m_led}, 1'b0);
    check({24'b0, m_led}, {24'b0, led_o}, "led_o");
    for (int c = 0; c < NUM_CH; c++) begin
      reg_read(cal_addr(c, 0), {{16{m_adc_gain[c][15]}}, m_adc_gain[c]}, 1'b0);
      reg_read(cal_addr(c, 1), {{18{m_adc_offs[c][13]}}, m_adc_offs[c]}, 1'b0);
      reg_read(cal_addr(c, 2), {{16{m_dac_gain[c][15]}}, m_dac_gain[c]}, 1'b0);
      reg_read(cal_addr(c, 3), {{18{m_dac_offs[c][13]}}, m_dac_offs[c]}, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sample streams
  //////////////////////////////////////////////////////////////////////

  // Checks start once the pipeline holds only new samples
  task automatic run_stream(input int n);
    int lat;
    int a_exp;
    int d_cal;
    lat = m_loop ? 4 : 3;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #1;
      for (int c = 0; c < NUM_CH; c++) begin
        if (i >= lat) check(dl_adc[c][lat-1], adc_dat_o[c], $sformatf("adc_dat_o[%0d]", c));
        if (i >= 3) begin
          check({18'b0, smp_to_code(dl_dac[c][2])}, {18'b0, dac_dat_o[c]},
                $sformatf("dac_dat_o[%0d]", c));
          if (dl_dac[c][2] == 8191) begin
            sat_hi++;
          end else if (dl_dac[c][2] == -8192) begin
            sat_lo++;
          end
        end
        adc_dat_i[c] = SMP_W'(rand_bits(SMP_W));
        dac_src_i[c] = sample_t'(rand_bits(SMP_W));
        d_cal = cal_model(int'(dac_src_i[c]), int'(m_dac_gain[c]), int'(m_dac_offs[c]));
        // Loopback feeds the calibrated DAC sample to the ADC calibration
        if (m_loop) begin
          a_exp = cal_model(d_cal, int'(m_adc_gain[c]), int'(m_adc_offs[c]));
        end else begin
          a_exp = cal_model(raw_to_smp(adc_dat_i[c]), int'(m_adc_gain[c]),
                            int'(m_adc_offs[c]));
        end
        for (int k = 3; k > 0; k--) begin
          dl_adc[c][k] = dl_adc[c][k-1];
          dl_dac[c][k] = dl_dac[c][k-1];
        end
        dl_adc[c][0] = a_exp;
        dl_dac[c][0] = d_cal;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] wd;
    lfsr      = 32'ha85f_b6be;
    cycles    = 0;
    sat_hi    = 0;
    sat_lo    = 0;
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    adc_dat_i = '0;
    m_loop    = 1'b0;
    m_led     = 8'h00;
    for (int c = 0; c < NUM_CH; c++) begin
      dac_src_i[c]  = '0;
      m_adc_gain[c] = gain_t'(16384);
      m_adc_offs[c] = '0;
      m_dac_gain[c] = gain_t'(16384);
      m_dac_offs[c] = '0;
    end
    repeat (16) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    // Reset values
    check_regs();

    // Random register traffic with readback
    repeat (8) begin
      wd = rand_bits(32);
      m_led = wd[7:0];
      reg_write(16'h0008, wd, 1'b0);
      wd = rand_bits(32);
      m_loop = wd[0];
      reg_write(16'h0004, wd, 1'b0);
      randomize_cal();
      check_regs();
    end
    set_loop(1'b0);

    // Error responses that must change nothing
    reg_read(16'h2000, 32'h0, 1'b1);
    reg_write(16'h2004, rand_bits(32), 1'b1);
    reg_write(16'h000c, rand_bits(32), 1'b1);
    reg_write(cal_addr(2, 0), rand_bits(32), 1'b1);
    reg_write(cal_addr(2, 3), rand_bits(32), 1'b1);
    reg_write(16'h0000, rand_bits(32), 1'b1);
    check_regs();

    // ADC and DAC paths with random calibration
    repeat (6) begin
      randomize_cal();
      run_stream(N_SMP);
    end

    // Extreme DAC gains drive both rails
    sat_hi = 0;
    sat_lo = 0;
    write_cal(0, 2, 32'h0000_7fff);
    write_cal(1, 2, 32'h0000_8000);
    run_stream(N_SMP);
    write_cal(0, 2, 32'h0000_8000);
    write_cal(1, 2, 32'h0000_7fff);
    run_stream(N_SMP);
    check(32'd1, {31'b0, sat_hi > 0}, "upper rail reached");
    check(32'd1, {31'b0, sat_lo > 0}, "lower rail reached");

    // Loopback and then back to the ADC input
    set_loop(1'b1);
    repeat (3) begin
      randomize_cal();
      run_stream(N_SMP);
    end
    set_loop(1'b0);
    run_stream(N_SMP);

    $display("Test passed");
    $finish;
  end

endmodule

// File: project.f
hw/afe_pkg.sv
hw/apb_if.sv
hw/apb_decoder.sv
hw/hk_regs.sv
hw/calib_regs.sv
hw/linear_cal.sv
hw/afe_channel.sv
hw/afe_top.sv
tests/afe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the AFE testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module afe_tb --Mdir obj_dir -o afe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/afe_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
